//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
TOP        ?= slot_tb
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
PASS_TEXT  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

//--- common/reel_if.sv
`include "slot_config.svh"

interface reel_if;

    // current symbol of each reel, reel 0 first
    slot_pkg::sym_t        syms [`NUM_REELS];
    // set while a reel is turning
    logic [`NUM_REELS-1:0] spinning;
    // ledger allows new spins
    logic                  spin_en;
    // one-cycle spin rate pulse
    logic                  spin_tick;

    modport bank (
        output syms,
        output spinning,
        input  spin_en,
        input  spin_tick
    );

    modport ledger (
        input  syms,
        input  spinning,
        output spin_en
    );

endinterface

//--- common/slot_config.svh
`ifndef SLOT_CONFIG_SVH
`define SLOT_CONFIG_SVH

// number of reels on the machine
`define NUM_REELS 4

// clock cycles between enable pulses
`define SPIN_DIV_FAST 4
`define SPIN_DIV_SLOW 16
`define SCAN_DIV 8

// reel LFSR seeds
`define REEL_SEED0 1
`define REEL_SEED1 4
`define REEL_SEED2 7
`define REEL_SEED3 9

// credit rules
`define COIN_START 3
`define PAY_FOUR 50
`define PAY_THREE 10

`endif

//--- common/slot_pkg.sv
package slot_pkg;

    //////////////////////////////
    // reel side
    //////////////////////////////

    // reel symbol, eight faces per reel
    typedef logic [2:0] sym_t;

    // reel LFSR state
    typedef logic [7:0] lfsr_t;

    //////////////////////////////
    // credit and display side
    //////////////////////////////

    // coin count, up to 1023
    typedef logic [9:0] coin_t;

    // one decimal digit of the coin count
    typedef logic [3:0] bcd_t;

    // ledger FSM, IDLE between rounds and ROUND while any reel spins
    typedef enum logic {
        IDLE  = 1'b0,
        ROUND = 1'b1
    } ledger_state_t;

endpackage

//--- display/ssd_driver.sv
module ssd_driver (
    input  logic            clk,
    input  logic            rst,
    input  logic            scan_tick,
    input  slot_pkg::coin_t coins,
    output logic [3:0]      ssd_ctl,
    output logic [7:0]      segs
);

    slot_pkg::bcd_t digits [4];
    slot_pkg::bcd_t cur_digit;
    logic [1:0]     idx;
    logic [1:0]     idx_next;
    logic [3:0]     sel_next;
    logic [7:0]     seg_next;

    //////////////////////////////
    // decimal split
    //////////////////////////////

    // index 0 is the ones digit
    assign digits[0] = slot_pkg::bcd_t'(coins % 10'd10);
    assign digits[1] = slot_pkg::bcd_t'((coins / 10'd10) % 10'd10);
    assign digits[2] = slot_pkg::bcd_t'((coins / 10'd100) % 10'd10);
    assign digits[3] = slot_pkg::bcd_t'(coins / 10'd1000);

    //////////////////////////////
    // scan and decode
    //////////////////////////////
    assign idx_next  = scan_tick ? idx + 2'd1 : idx;
    assign cur_digit = digits[idx_next];

    // active low one-hot select
    assign sel_next = ~(4'b0001 << idx_next);

    // active low, dp off in bit 7, then g down to a
    always_comb begin
        case (cur_digit)
            4'd0:    seg_next = 8'hc0;
            4'd1:    seg_next = 8'hf9;
            4'd2:    seg_next = 8'ha4;
            4'd3:    seg_next = 8'hb0;
            4'd4:    seg_next = 8'h99;
            4'd5:    seg_next = 8'h92;
            4'd6:    seg_next = 8'h82;
            4'd7:    seg_next = 8'hf8;
            4'd8:    seg_next = 8'h80;
            4'd9:    seg_next = 8'h90;
            default: seg_next = 8'hff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idx     <= 2'd0;
            ssd_ctl <= 4'b1110;
        end else begin
            idx     <= idx_next;
            ssd_ctl <= sel_next;
        end
    end

    // segment pattern follows the selected digit every cycle
    always_ff @(posedge clk) begin
        segs <= seg_next;
    end

endmodule

//--- logic/coin_ledger.sv
`include "slot_config.svh"

module coin_ledger (
    input  logic            clk,
    input  logic            rst,
    input  logic            power,
    reel_if.ledger          reels,
    output slot_pkg::coin_t coins
);

    slot_pkg::ledger_state_t state;
    logic [2:0]              match_cnt [`NUM_REELS];
    logic [2:0]              best_cnt;
    slot_pkg::coin_t         payout;

    //////////////////////////////
    // payout rule
    //////////////////////////////

    // how many reels show the most frequent symbol
    always_comb begin
        best_cnt = '0;
        for (int i = 0; i < `NUM_REELS; i++) begin
            match_cnt[i] = '0;
            for (int j = 0; j < `NUM_REELS; j++) begin
                match_cnt[i] = match_cnt[i] + 3'(reels.syms[j] == reels.syms[i]);
            end
            if (match_cnt[i] > best_cnt) begin
                best_cnt = match_cnt[i];
            end
        end
    end

    always_comb begin
        case (best_cnt)
            3'd4:    payout = slot_pkg::coin_t'(`PAY_FOUR);
            3'd3:    payout = slot_pkg::coin_t'(`PAY_THREE);
            default: payout = '0;
        endcase
    end

    //////////////////////////////
    // round FSM
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= slot_pkg::IDLE;
            coins <= slot_pkg::coin_t'(`COIN_START);
        end else begin
            case (state)
                slot_pkg::IDLE: begin
                    // first reel turning starts the round, charge one coin
                    if (|reels.spinning) begin
                        state <= slot_pkg::ROUND;
                        coins <= coins - 10'd1;
                    end
                end
                slot_pkg::ROUND: begin
                    // all reels at rest, settle the round
                    if (reels.spinning == '0) begin
                        state <= slot_pkg::IDLE;
                        coins <= coins + payout;
                    end
                end
                default: begin
                    state <= slot_pkg::IDLE;
                end
            endcase
        end
    end

    // an empty purse blocks new rounds, a running round may go on
    assign reels.spin_en = power & ((coins != '0) | (state == slot_pkg::ROUND));

endmodule

//--- logic/slot_machine_top.sv
`include "slot_config.svh"

module slot_machine_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        slow,
    input  logic        power,
    input  logic [3:0]  rod,
    output logic [3:0]  ssd_ctl,
    output logic [7:0]  segs,
    output logic [15:0] leds
);

    logic            spin_tick;
    logic            scan_tick;
    slot_pkg::coin_t coins;

    reel_if reels ();

    assign reels.spin_tick = spin_tick;

    tick_gen u_tick_gen (
        .clk       (clk),
        .rst       (rst),
        .slow      (slow),
        .spin_tick (spin_tick),
        .scan_tick (scan_tick)
    );

    reel_bank u_reel_bank (
        .clk   (clk),
        .rst   (rst),
        .rod   (rod),
        .reels (reels.bank)
    );

    coin_ledger u_coin_ledger (
        .clk   (clk),
        .rst   (rst),
        .power (power),
        .reels (reels.ledger),
        .coins (coins)
    );

    ssd_driver u_ssd_driver (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .coins     (coins),
        .ssd_ctl   (ssd_ctl),
        .segs      (segs)
    );

    // one nibble per reel, reel 0 lowest
    for (genvar i = 0; i < `NUM_REELS; i++) begin : g_leds
        assign leds[4*i +: 4] = {1'b0, reels.syms[i]};
    end

endmodule

//--- logic/tick_gen.sv
`include "slot_config.svh"

module tick_gen (
    input  logic clk,
    input  logic rst,
    input  logic slow,
    output logic spin_tick,
    output logic scan_tick
);

    localparam int SPIN_W = $clog2(`SPIN_DIV_SLOW);
    localparam int SCAN_W = $clog2(`SCAN_DIV);

    logic [SPIN_W-1:0] spin_cnt;
    logic [SPIN_W-1:0] spin_load;
    logic [SCAN_W-1:0] scan_cnt;
    logic              slow_q;

    // reload value picked by the rate switch
    assign spin_load = slow ? SPIN_W'(`SPIN_DIV_SLOW - 1) : SPIN_W'(`SPIN_DIV_FAST - 1);

    //////////////////////////////
    // spin rate
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            spin_cnt  <= '0;
            slow_q    <= 1'b0;
            spin_tick <= 1'b0;
        end else begin
            slow_q    <= slow;
            spin_tick <= (spin_cnt == '0);
            // a flip of the rate switch starts a fresh period
            if (spin_cnt == '0 || slow != slow_q) begin
                spin_cnt <= spin_load;
            end else begin
                spin_cnt <= spin_cnt - 1'b1;
            end
        end
    end

    //////////////////////////////
    // display scan rate
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            scan_cnt  <= '0;
            scan_tick <= 1'b0;
        end else begin
            scan_tick <= (scan_cnt == '0);
            if (scan_cnt == '0) begin
                scan_cnt <= SCAN_W'(`SCAN_DIV - 1);
            end else begin
                scan_cnt <= scan_cnt - 1'b1;
            end
        end
    end

endmodule

//--- reel/reel_bank.sv
`include "slot_config.svh"

module reel_bank (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`NUM_REELS-1:0] rod,
    reel_if.bank                  reels
);

    localparam slot_pkg::lfsr_t SEEDS [`NUM_REELS] = '{
        slot_pkg::lfsr_t'(`REEL_SEED0),
        slot_pkg::lfsr_t'(`REEL_SEED1),
        slot_pkg::lfsr_t'(`REEL_SEED2),
        slot_pkg::lfsr_t'(`REEL_SEED3)
    };

    slot_pkg::lfsr_t       lfsr      [`NUM_REELS];
    slot_pkg::lfsr_t       lfsr_step [`NUM_REELS];
    logic [`NUM_REELS-1:0] spin_q;

    // fibonacci step, taps 7 5 4 3 shifted in at bit 0
    always_comb begin
        for (int i = 0; i < `NUM_REELS; i++) begin
            lfsr_step[i] = {lfsr[i][6:0], lfsr[i][7] ^ lfsr[i][5] ^ lfsr[i][4] ^ lfsr[i][3]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spin_q <= '0;
            for (int i = 0; i < `NUM_REELS; i++) begin
                lfsr[i] <= SEEDS[i];
            end
        end else if (reels.spin_tick) begin
            for (int i = 0; i < `NUM_REELS; i++) begin
                spin_q[i] <= rod[i] & reels.spin_en;
                // advance only if the reel was already turning
                if (spin_q[i]) begin
                    lfsr[i] <= lfsr_step[i];
                end
            end
        end
    end

    assign reels.spinning = spin_q;

    // symbol is the low three bits of the LFSR
    always_comb begin
        for (int i = 0; i < `NUM_REELS; i++) begin
            reels.syms[i] = lfsr[i][2:0];
        end
    end

endmodule

//--- testbench/slot_checker.sv
`include "slot_config.svh"

module slot_checker (
    input logic        clk,
    input logic        rst,
    input logic        slow,
    input logic        power,
    input logic [3:0]  rod,
    input logic [3:0]  ssd_ctl,
    input logic [7:0]  segs,
    input logic [15:0] leds
);

    int         errors = 0;
    int         step_errors = 0;
    int         tests = 0;
    int         failed_tests = 0;

    // reference model state
    int         spin_cnt;
    int         scan_cnt;
    bit         tick;
    bit         scan_tick;
    bit         slow_q;
    logic [3:0] spin;
    logic [7:0] lfsr [4];
    bit         in_round;
    int         coins;
    int         idx;
    logic [3:0] ctl;
    logic [7:0] seg;

    function automatic logic [7:0] lfsr_next(input logic [7:0] v);
        return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
    endfunction

    function automatic logic [7:0] seg_pattern(input int d);
        case (d)
            0: return 8'hc0;
            1: return 8'hf9;
            2: return 8'ha4;
            3: return 8'hb0;
            4: return 8'h99;
            5: return 8'h92;
            6: return 8'h82;
            7: return 8'hf8;
            8: return 8'h80;
            9: return 8'h90;
            default: return 8'hff;
        endcase
    endfunction

    // active low digit select, ones digit first
    function automatic logic [3:0] select_of(input int k);
        case (k)
            0: return 4'b1110;
            1: return 4'b1101;
            2: return 4'b1011;
            default: return 4'b0111;
        endcase
    endfunction

    function automatic int digit_of(input int c, input int k);
        case (k)
            0: return c % 10;
            1: return (c / 10) % 10;
            2: return (c / 100) % 10;
            default: return c / 1000;
        endcase
    endfunction

    // most frequent symbol decides the win
    function automatic int payout_of(input logic [2:0] a, input logic [2:0] b,
                                     input logic [2:0] c, input logic [2:0] d);
        logic [2:0] s [4];
        int         best;
        int         n;
        s = '{a, b, c, d};
        best = 0;
        for (int i = 0; i < 4; i++) begin
            n = 0;
            for (int j = 0; j < 4; j++) begin
                if (s[j] == s[i]) n++;
            end
            if (n > best) best = n;
        end
        if (best == 4) return `PAY_FOUR;
        if (best == 3) return `PAY_THREE;
        return 0;
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int act);
        $display("CHECK FAILED time %0t %s expected %0h actual %0h", $time, name, exp, act);
        errors++;
        step_errors++;
    endtask

    //////////////////////////////
    // cycle model
    //////////////////////////////
    always @(posedge clk) begin : model
        bit         en;
        bit         n_round;
        int         n_coins;
        logic [3:0] n_spin;
        int         n_idx;
        if (rst) begin
            spin_cnt  = 0;
            scan_cnt  = 0;
            tick      = 0;
            scan_tick = 0;
            slow_q    = 0;
            spin      = '0;
            lfsr      = '{8'(`REEL_SEED0), 8'(`REEL_SEED1), 8'(`REEL_SEED2), 8'(`REEL_SEED3)};
            in_round  = 0;
            coins     = `COIN_START;
            idx       = 0;
            ctl       = 4'b1110;
            seg       = seg_pattern(`COIN_START % 10);
        end else begin
            en = power && (coins != 0 || in_round);
            // ledger sees the symbols before this edge
            n_round = in_round;
            n_coins = coins;
            if (!in_round && spin != '0) begin
                n_round = 1;
                n_coins = coins - 1;
            end else if (in_round && spin == '0) begin
                n_round = 0;
                n_coins = coins + payout_of(lfsr[0][2:0], lfsr[1][2:0],
                                            lfsr[2][2:0], lfsr[3][2:0]);
            end
            n_spin = spin;
            if (tick) begin
                for (int i = 0; i < 4; i++) begin
                    if (spin[i]) lfsr[i] = lfsr_next(lfsr[i]);
                    n_spin[i] = rod[i] & en;
                end
            end
            n_idx = scan_tick ? (idx + 1) % 4 : idx;
            ctl   = select_of(n_idx);
            seg   = seg_pattern(digit_of(coins, n_idx));
            idx   = n_idx;
            tick  = (spin_cnt == 0);
            if (spin_cnt == 0 || slow != slow_q) begin
                spin_cnt = slow ? `SPIN_DIV_SLOW - 1 : `SPIN_DIV_FAST - 1;
            end else begin
                spin_cnt = spin_cnt - 1;
            end
            slow_q    = slow;
            scan_tick = (scan_cnt == 0);
            scan_cnt  = (scan_cnt == 0) ? `SCAN_DIV - 1 : scan_cnt - 1;
            spin      = n_spin;
            coins     = n_coins;
            in_round  = n_round;
        end
    end

    // outputs are stable on the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 4; i++) begin
                if (leds[4*i +: 4] !== {1'b0, lfsr[i][2:0]}) begin
                    report_mismatch($sformatf("leds[%0d]", i), {1'b0, lfsr[i][2:0]},
                                    leds[4*i +: 4]);
                end
            end
            if (ssd_ctl !== ctl) report_mismatch("ssd_ctl", ctl, ssd_ctl);
            if (segs !== seg) report_mismatch("segs", seg, segs);
        end
    end

    task automatic check_reset();
        logic [15:0] exp_leds;
        exp_leds = {1'b0, 3'(`REEL_SEED3), 1'b0, 3'(`REEL_SEED2),
                    1'b0, 3'(`REEL_SEED1), 1'b0, 3'(`REEL_SEED0)};
        if (leds !== exp_leds) report_mismatch("leds", exp_leds, leds);
        if (ssd_ctl !== 4'b1110) report_mismatch("ssd_ctl", 4'b1110, ssd_ctl);
        if (segs !== seg_pattern(`COIN_START % 10)) begin
            report_mismatch("segs", seg_pattern(`COIN_START % 10), segs);
        end
        finish_test("reset state");
    endtask

    task automatic finish_step(input int step, input int expected);
        if (coins != expected) report_mismatch("coins", expected, coins);
        finish_test($sformatf("trace step %0d", step));
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (step_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, step_errors);
            failed_tests++;
        end
        step_errors = 0;
    endtask

    task automatic report_totals(input int assert_fails);
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests, failed_tests, errors, assert_fails);
    endtask

endmodule

//--- testbench/slot_sva.sv
module slot_sva (
    input logic       clk,
    input logic       rst,
    input logic       spin_tick,
    input logic [3:0] ssd_ctl,
    input logic [3:0] spinning
);

    // failed assertion count, read at the end of the run
    int fail_count = 0;

    // a spin pulse lasts a single cycle
    a_tick_single: assert property (@(posedge clk) disable iff (rst)
        spin_tick |=> !spin_tick)
        else begin
            fail_count++;
            $error("spin_tick high for two cycles");
        end

    // exactly one digit selected, active low
    a_ctl_onehot: assert property (@(posedge clk) disable iff (rst)
        $countones(~ssd_ctl) == 1)
        else begin
            fail_count++;
            $error("ssd_ctl does not select exactly one digit");
        end

    // reel start and stop only follow a spin pulse
    a_spin_on_tick: assert property (@(posedge clk) disable iff (rst)
        $changed(spinning) |-> $past(spin_tick))
        else begin
            fail_count++;
            $error("spinning changed without a spin pulse");
        end

endmodule

bind slot_machine_top slot_sva u_slot_sva (
    .clk       (clk),
    .rst       (rst),
    .spin_tick (spin_tick),
    .ssd_ctl   (ssd_ctl),
    .spinning  (reels.spinning)
);

//--- testbench/slot_tb.sv
`include "slot_config.svh"

module slot_tb;

    logic        clk;
    logic        rst;
    logic        slow;
    logic        power;
    logic [3:0]  rod;
    logic [3:0]  ssd_ctl;
    logic [7:0]  segs;
    logic [15:0] leds;

    // trace columns, one entry per step
    int          step_cycles [$];
    logic        step_power  [$];
    logic        step_slow   [$];
    logic [3:0]  step_rod    [$];
    int          step_coins  [$];
    int          total_cycles;
    bit          loaded;

    slot_machine_top u_slot_machine_top (
        .clk     (clk),
        .rst     (rst),
        .slow    (slow),
        .power   (power),
        .rod     (rod),
        .ssd_ctl (ssd_ctl),
        .segs    (segs),
        .leds    (leds)
    );

    slot_checker u_checker (
        .clk     (clk),
        .rst     (rst),
        .slow    (slow),
        .power   (power),
        .rod     (rod),
        .ssd_ctl (ssd_ctl),
        .segs    (segs),
        .leds    (leds)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // returns 0 if the file cannot be opened
    function automatic bit read_trace();
        int    fd;
        int    n;
        int    c;
        int    p;
        int    s;
        int    r;
        int    e;
        string line;
        fd = $fopen("testbench/slot_trace.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %d %h %h", c, p, s, r, e);
                if (n == 5) begin
                    step_cycles.push_back(c);
                    step_power.push_back(p[0]);
                    step_slow.push_back(s[0]);
                    step_rod.push_back(r[3:0]);
                    step_coins.push_back(e);
                    total_cycles += c;
                end
            end
        end
        $fclose(fd);
        return 1'b1;
    endfunction

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial begin
        rst          = 1'b1;
        slow         = 1'b0;
        power        = 1'b0;
        rod          = 4'b0000;
        total_cycles = 0;
        loaded       = 1'b0;
        if (!read_trace()) begin
            $display("could not open the trace file testbench/slot_trace.txt");
            $display("*** FAILED ***");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (10) @(posedge clk);
            rst <= 1'b0;
            @(negedge clk);
            u_checker.check_reset();
            foreach (step_cycles[i]) begin
                @(posedge clk);
                power <= step_power[i];
                slow  <= step_slow[i];
                rod   <= step_rod[i];
                repeat (step_cycles[i] - 1) @(posedge clk);
                @(negedge clk);
                u_checker.finish_step(i + 1, step_coins[i]);
            end
            u_checker.report_totals(u_slot_machine_top.u_slot_sva.fail_count);
            if (u_checker.errors == 0 && u_slot_machine_top.u_slot_sva.fail_count == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

    // run limit from the trace length plus margin
    initial begin
        wait (loaded);
        #((total_cycles + 210) * 40);
        $display("timeout, the trace did not complete in %0d cycles", total_cycles + 210);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- testbench/slot_trace.txt
# cycles power slow rod(hex) expected_coins(hex)
# only reel 0 spins with power, so no win is possible
20 1 0 0 3
40 1 0 1 2
30 1 0 0 2
40 1 1 1 1
40 1 1 0 1
20 0 0 f 1
40 1 0 1 0
40 1 0 0 0
40 1 0 f 0
30 1 1 0 0

//--- vlog.f
+incdir+common
common/slot_pkg.sv
common/reel_if.sv
logic/tick_gen.sv
reel/reel_bank.sv
logic/coin_ledger.sv
display/ssd_driver.sv
logic/slot_machine_top.sv
testbench/slot_sva.sv
testbench/slot_checker.sv
testbench/slot_tb.sv
